// File: Bender.yml
package:
  name: periph_subsystem

sources:
  - files:
      - common/periph_bus_pkg.sv
      - common/periph_map_pkg.sv
      - gpio/periph_gpio.sv
      - timer/periph_timer.sv
      - hdl/periph_int_ctrl.sv
      - hdl/periph_subsystem.sv
  - target: simulation
    files:
      - sim/tb_periph_subsystem.sv

// File: common/periph_bus_pkg.sv
/* bus signalling types for the peripheral block
   data width, per-block request and response structs */
package periph_bus_pkg;

    localparam int data_width = 8;

    // one per block, built by the address decoder
    typedef struct packed {
        logic [3:0]            offset;
        logic [data_width-1:0] wdata;
        logic                  we;
    } bus_req_t;

    // zero when the block is not selected
    typedef struct packed {
        logic [data_width-1:0] rdata;
    } bus_rsp_t;

endpackage

// File: common/periph_map_pkg.sv
/* register map of the peripheral window
   block offsets and sizes, local register offsets, block and source enums */
package periph_map_pkg;

    localparam int window_size = 10;

    // block placement inside the window
    localparam int gpio_off   = 0;
    localparam int gpio_size  = 4;
    localparam int timer_off  = 4;
    localparam int timer_size = 3;
    localparam int intc_off   = 7;
    localparam int intc_size  = 3;

    // gpio registers
    localparam logic [3:0] gpio_reg_gpi   = 4'd0;
    localparam logic [3:0] gpio_reg_gpo   = 4'd1;
    localparam logic [3:0] gpio_reg_mask  = 4'd2;
    localparam logic [3:0] gpio_reg_flags = 4'd3;

    // timer registers
    localparam logic [3:0] timer_reg_ctrl   = 4'd0;
    localparam logic [3:0] timer_reg_reload = 4'd1;
    localparam logic [3:0] timer_reg_count  = 4'd2;

    // interrupt controller registers
    localparam logic [3:0] intc_reg_mask = 4'd0;
    localparam logic [3:0] intc_reg_pend = 4'd1;
    localparam logic [3:0] intc_reg_src  = 4'd2;

    typedef enum logic [1:0] {
        blk_none,
        blk_gpio,
        blk_timer,
        blk_intc
    } periph_block_t;

    typedef enum logic [1:0] {
        src_none  = 2'd0,
        src_gpio  = 2'd1,
        src_timer = 2'd2
    } int_source_t;

endpackage

// File: compile.f
common/periph_bus_pkg.sv
common/periph_map_pkg.sv
gpio/periph_gpio.sv
timer/periph_timer.sv
hdl/periph_int_ctrl.sv
hdl/periph_subsystem.sv
sim/tb_periph_subsystem.sv

// File: gpio/periph_gpio.sv
/* gpio port with output register, input sampling,
   rising-edge flags with mask and level interrupt */
`timescale 1ns/10ps

module periph_gpio
    import periph_bus_pkg::*, periph_map_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       sel,
    input  bus_req_t   req,
    output bus_rsp_t   rsp,
    input  logic [7:0] gpi,
    output logic [7:0] gpo,
    output logic       irq
);

    logic [7:0] gpi_q;
    logic [7:0] gpi_prev;
    logic [7:0] mask;
    logic [7:0] flags;
    logic [7:0] rise;
    logic [7:0] clr;

    assign rise = gpi_q & ~gpi_prev;
    assign clr  = (req.we && req.offset == gpio_reg_flags) ? req.wdata : 8'h00;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            gpi_q    <= '0;
            gpi_prev <= '0;
            gpo      <= '0;
            mask     <= '0;
            flags    <= '0;
        end
        else
        begin
            gpi_q    <= gpi;
            gpi_prev <= gpi_q;
            // a new edge wins over a clear in the same cycle
            flags    <= (flags & ~clr) | rise;
            if (req.we && req.offset == gpio_reg_gpo)
                gpo <= req.wdata;
            if (req.we && req.offset == gpio_reg_mask)
                mask <= req.wdata;
        end
    end

    assign irq = |(flags & mask);

    always_comb
    begin
        rsp.rdata = '0;
        if (sel)
        begin
            case (req.offset)
                gpio_reg_gpi:   rsp.rdata = gpi_q;
                gpio_reg_gpo:   rsp.rdata = gpo;
                gpio_reg_mask:  rsp.rdata = mask;
                gpio_reg_flags: rsp.rdata = flags;
                default:        rsp.rdata = '0;
            endcase
        end
    end

    // a zero mask write silences the interrupt from the next cycle on
    a_irq_needs_mask: assert property (@(posedge clk) disable iff (reset)
        (req.we && req.offset == gpio_reg_mask && req.wdata == '0) |=> !irq);

endmodule

// File: hdl/periph_int_ctrl.sv
/* interrupt controller with pending latch, enable mask,
   priority encoder for the source code and the cpu interrupt line */
`timescale 1ns/10ps

module periph_int_ctrl
    import periph_bus_pkg::*, periph_map_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     sel,
    input  bus_req_t req,
    output bus_rsp_t rsp,
    input  logic     gpio_irq,
    input  logic     timer_irq,
    output logic     cpu_int
);

    logic [1:0]  pending;
    logic [1:0]  mask;
    logic [1:0]  active;
    logic [1:0]  clr;
    int_source_t source;

    assign clr = (req.we && req.offset == intc_reg_pend) ? req.wdata[1:0] : 2'b00;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pending <= '0;
            mask    <= '0;
        end
        else
        begin
            // bit0 gpio, bit1 timer
            // a live request beats the clear
            pending <= (pending & ~clr) | {timer_irq, gpio_irq};
            if (req.we && req.offset == intc_reg_mask)
                mask <= req.wdata[1:0];
        end
    end

    assign active  = pending & mask;
    assign cpu_int = |active;

    // gpio has the higher priority
    always_comb
    begin
        if (active[0])
            source = src_gpio;
        else if (active[1])
            source = src_timer;
        else
            source = src_none;
    end

    always_comb
    begin
        rsp.rdata = '0;
        if (sel)
        begin
            case (req.offset)
                intc_reg_mask: rsp.rdata = {{(data_width-2){1'b0}}, mask};
                intc_reg_pend: rsp.rdata = {{(data_width-2){1'b0}}, pending};
                intc_reg_src:  rsp.rdata = {{(data_width-2){1'b0}}, source};
                default:       rsp.rdata = '0;
            endcase
        end
    end

    // source register as read over the bus
    a_int_matches_source: assert property (@(posedge clk) disable iff (reset)
        (sel && req.offset == intc_reg_src) |-> (cpu_int == (rsp.rdata != '0)));

endmodule

// File: hdl/periph_subsystem.sv
/* peripheral block top with address window decode, per-block requests,
   read data OR and the gpio, timer and interrupt controller instances */
`timescale 1ns/10ps

module periph_subsystem
    import periph_bus_pkg::*, periph_map_pkg::*;
#(
    parameter logic [15:0] base_addr      = 16'hFF00,
    parameter int          timer_prescale = 4
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,
    input  logic [15:0]           addr,
    input  logic [data_width-1:0] data_in,
    input  logic                  write_en,
    output logic [data_width-1:0] data_out,
    input  logic [7:0]            gpi,
    output logic [7:0]            gpo,
    output logic                  cpu_int
);

    logic          in_window;
    logic [3:0]    win_off;
    logic [3:0]    local_off;
    periph_block_t target;
    logic          sel_gpio, sel_timer, sel_intc;
    bus_req_t      req_gpio, req_timer, req_intc;
    bus_rsp_t      rsp_gpio, rsp_timer, rsp_intc;
    logic          gpio_irq, timer_irq;

    // 17-bit compare so a window at the top of memory does not wrap
    assign in_window = enable && (addr >= base_addr) &&
                       ({1'b0, addr} < 17'(base_addr) + 17'(window_size));
    assign win_off   = 4'(addr - base_addr);

    always_comb
    begin
        target    = blk_none;
        local_off = '0;
        if (in_window)
        begin
            if (win_off < 4'(gpio_off + gpio_size))
            begin
                target    = blk_gpio;
                local_off = win_off - 4'(gpio_off);
            end
            else if (win_off < 4'(timer_off + timer_size))
            begin
                target    = blk_timer;
                local_off = win_off - 4'(timer_off);
            end
            else if (win_off < 4'(intc_off + intc_size))
            begin
                target    = blk_intc;
                local_off = win_off - 4'(intc_off);
            end
        end
    end

    assign sel_gpio  = (target == blk_gpio);
    assign sel_timer = (target == blk_timer);
    assign sel_intc  = (target == blk_intc);

    assign req_gpio  = '{offset: local_off, wdata: data_in, we: write_en && sel_gpio};
    assign req_timer = '{offset: local_off, wdata: data_in, we: write_en && sel_timer};
    assign req_intc  = '{offset: local_off, wdata: data_in, we: write_en && sel_intc};

    // unselected blocks return zero
    assign data_out = rsp_gpio.rdata | rsp_timer.rdata | rsp_intc.rdata;

    periph_gpio u_gpio (
        .clk   (clk),
        .reset (reset),
        .sel   (sel_gpio),
        .req   (req_gpio),
        .rsp   (rsp_gpio),
        .gpi   (gpi),
        .gpo   (gpo),
        .irq   (gpio_irq)
    );

    periph_timer #(.prescale(timer_prescale)) u_timer (
        .clk   (clk),
        .reset (reset),
        .sel   (sel_timer),
        .req   (req_timer),
        .rsp   (rsp_timer),
        .irq   (timer_irq)
    );

    periph_int_ctrl u_int_ctrl (
        .clk       (clk),
        .reset     (reset),
        .sel       (sel_intc),
        .req       (req_intc),
        .rsp       (rsp_intc),
        .gpio_irq  (gpio_irq),
        .timer_irq (timer_irq),
        .cpu_int   (cpu_int)
    );

    // at most one block drives the read data OR
    a_one_block_selected: assert property (@(posedge clk) disable iff (reset)
        $onehot0({|rsp_gpio.rdata, |rsp_timer.rdata, |rsp_intc.rdata}));

endmodule

// File: sim/tb_periph_subsystem.sv
/* testbench for the peripheral block with a stimulus table, clock and reset,
   typed compare tasks and a cycle limit */
`timescale 1ns/10ps

module tb_periph_subsystem
    import periph_bus_pkg::*, periph_map_pkg::*;
();

    localparam logic [15:0] base_addr      = 16'hFF00;
    localparam int          timer_prescale = 4;
    localparam int          max_entries    = 96;

    // window offsets of each register
    localparam logic [3:0] off_gpi    = 4'(gpio_off + gpio_reg_gpi);
    localparam logic [3:0] off_gpo    = 4'(gpio_off + gpio_reg_gpo);
    localparam logic [3:0] off_mask   = 4'(gpio_off + gpio_reg_mask);
    localparam logic [3:0] off_flags  = 4'(gpio_off + gpio_reg_flags);
    localparam logic [3:0] off_ctrl   = 4'(timer_off + timer_reg_ctrl);
    localparam logic [3:0] off_reload = 4'(timer_off + timer_reg_reload);
    localparam logic [3:0] off_count  = 4'(timer_off + timer_reg_count);
    localparam logic [3:0] off_imask  = 4'(intc_off + intc_reg_mask);
    localparam logic [3:0] off_pend   = 4'(intc_off + intc_reg_pend);
    localparam logic [3:0] off_src    = 4'(intc_off + intc_reg_src);

    typedef enum logic [2:0] {
        op_write,
        op_read,
        op_set_gpi,
        op_wait,
        op_check_int,
        op_check_src
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  expv;
    } entry_t;

    logic                  clk;
    logic                  reset;
    logic                  enable;
    logic [15:0]           addr;
    logic [data_width-1:0] data_in;
    logic                  write_en;
    logic [data_width-1:0] data_out;
    logic [7:0]            gpi;
    logic [7:0]            gpo;
    logic                  cpu_int;

    entry_t     tbl [0:max_entries-1];
    string      names [0:max_entries-1];
    logic [7:0] model [0:window_size-1];
    int         n_entries   = 0;
    int         max_wait    = 0;
    int         cycle_limit = 0;
    int         cycles      = 0;
    int         data_errors = 0;
    int         int_errors  = 0;
    int         src_errors  = 0;
    integer     seed;

    periph_subsystem #(
        .base_addr      (base_addr),
        .timer_prescale (timer_prescale)
    ) u_dut (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .addr     (addr),
        .data_in  (data_in),
        .write_en (write_en),
        .data_out (data_out),
        .gpi      (gpi),
        .gpo      (gpo),
        .cpu_int  (cpu_int)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        if (!reset)
        begin
            cycles = cycles + 1;
            if (cycles > cycle_limit)
            begin
                $display("timeout: the stimulus table did not finish in %0d cycles", cycle_limit);
                $display("STATUS: FAIL");
                $finish;
            end
        end
    end

    task automatic check_data(input string name, input logic [data_width-1:0] expv,
                              input logic [data_width-1:0] act);
        if (act !== expv)
        begin
            data_errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expv, act);
        end
    endtask

    task automatic check_int(input string name, input logic expv, input logic act);
        if (act !== expv)
        begin
            int_errors++;
            $display("Mismatch %s: expected %b, actual %b", name, expv, act);
        end
    endtask

    task automatic check_src(input string name, input int_source_t expv,
                             input int_source_t act);
        if (act !== expv)
        begin
            src_errors++;
            $display("Mismatch %s: expected %0d, actual %0d", name, expv, act);
        end
    endtask

    task automatic push_entry(input string name, input op_t op, input logic [15:0] a,
                              input logic [7:0] d, input logic [7:0] e);
        tbl[n_entries].op   = op;
        tbl[n_entries].addr = a;
        tbl[n_entries].data = d;
        tbl[n_entries].expv = e;
        names[n_entries]    = name;
        if (op == op_wait && int'(d) > max_wait)
            max_wait = int'(d);
        n_entries++;
    endtask

    // plain read/write registers track their last write in the model
    task automatic write_reg(input string name, input logic [3:0] off, input logic [7:0] d);
        push_entry(name, op_write, base_addr + 16'(off), d, 8'h00);
        if (off == off_gpo || off == off_mask || off == off_reload || off == off_imask)
            model[off] = d;
        else if (off == off_ctrl)
            model[off] = d & 8'h03;
    endtask

    task automatic read_reg(input string name, input logic [3:0] off, input logic [7:0] e);
        push_entry(name, op_read, base_addr + 16'(off), 8'h00, e);
    endtask

    task automatic expect_int(input string name, input logic level);
        push_entry(name, op_check_int, 16'h0000, 8'h00, {7'b0, level});
    endtask

    task automatic expect_src(input string name, input int_source_t s);
        push_entry(name, op_check_src, base_addr + 16'(off_src), 8'h00, {6'b0, s});
    endtask

    task automatic build_table();
        integer     rnd;
        logic [7:0] gpo_val;
        logic [7:0] mask_val;
        logic [7:0] gpi_base;
        logic [7:0] edge_bit;
        logic [7:0] tmr_n;
        logic [7:0] wait_early;
        logic [7:0] wait_late;
        gpi_base   = 8'hA5;
        edge_bit   = 8'h02;
        tmr_n      = 8'd5;
        wait_early = 8'(tmr_n * timer_prescale - timer_prescale);
        // total lands past (n+1)*prescale from the run write
        wait_late  = 8'(2 * timer_prescale + 4);
        for (int r = 0; r < window_size; r++)
            model[r] = 8'h00;

        for (int r = 0; r < window_size; r++)
            read_reg($sformatf("reset read offset %0d", r), 4'(r), 8'h00);
        expect_int("reset cpu_int", 1'b0);
        push_entry("read below window", op_read, base_addr - 16'd1, 8'h00, 8'h00);
        push_entry("read above window", op_read, base_addr + 16'(window_size), 8'h00, 8'h00);
        push_entry("write below window", op_write, base_addr - 16'd1, 8'hFF, 8'h00);
        push_entry("write above window", op_write, base_addr + 16'(window_size), 8'hFF, 8'h00);
        // these alias onto gpo and the gpio mask if the window bounds are ignored
        push_entry("write below window alias", op_write, base_addr - 16'd15, 8'hFF, 8'h00);
        push_entry("write above window alias", op_write, base_addr + 16'd18, 8'hFF, 8'h00);
        for (int r = 0; r < window_size; r++)
            read_reg($sformatf("stray write offset %0d", r), 4'(r), 8'h00);

        rnd     = $random(seed);
        gpo_val = rnd[7:0];
        write_reg("gpo write", off_gpo, gpo_val);
        read_reg("gpo readback", off_gpo, model[off_gpo]);
        push_entry("gpi drive", op_set_gpi, 16'h0000, gpi_base, 8'h00);
        push_entry("gpi settle", op_wait, 16'h0000, 8'd2, 8'h00);
        read_reg("gpi sample", off_gpi, gpi_base);
        read_reg("flags after gpi rise", off_flags, gpi_base);
        write_reg("flags clear all", off_flags, 8'hFF);
        read_reg("flags cleared", off_flags, 8'h00);

        // the edge bit must be in the mask
        rnd      = $random(seed);
        mask_val = rnd[7:0] | edge_bit;
        write_reg("gpio mask write", off_mask, mask_val);
        read_reg("gpio mask readback", off_mask, model[off_mask]);
        push_entry("gpi rise", op_set_gpi, 16'h0000, gpi_base | edge_bit, 8'h00);
        push_entry("rise settle", op_wait, 16'h0000, 8'd2, 8'h00);
        read_reg("flag on masked rise", off_flags, edge_bit);
        expect_int("cpu_int before enable", 1'b0);
        write_reg("intc enable gpio", off_imask, 8'h01);
        expect_int("cpu_int on gpio edge", 1'b1);
        expect_src("source gpio", src_gpio);
        read_reg("pending gpio", off_pend, 8'h01);
        write_reg("flag clear", off_flags, edge_bit);
        write_reg("pending clear gpio", off_pend, 8'h01);
        expect_int("cpu_int after clear", 1'b0);
        expect_src("source after clear", src_none);
        push_entry("gpi fall", op_set_gpi, 16'h0000, gpi_base, 8'h00);
        push_entry("fall settle", op_wait, 16'h0000, 8'd2, 8'h00);
        read_reg("no flag on fall", off_flags, 8'h00);
        expect_int("cpu_int after fall", 1'b0);

        write_reg("timer reload", off_reload, tmr_n);
        read_reg("timer count loaded", off_count, tmr_n);
        read_reg("timer reload readback", off_reload, model[off_reload]);
        write_reg("timer run one-shot", off_ctrl, 8'h01);
        push_entry("timer early wait", op_wait, 16'h0000, wait_early, 8'h00);
        read_reg("timer pending early", off_pend, 8'h00);
        push_entry("timer late wait", op_wait, 16'h0000, wait_late, 8'h00);
        read_reg("timer pending late", off_pend, 8'h02);
        // one-shot drops run at the zero tick
        model[off_ctrl] = 8'h00;
        read_reg("timer stopped", off_ctrl, model[off_ctrl]);
        read_reg("timer count at zero", off_count, 8'h00);

        push_entry("gpi rise again", op_set_gpi, 16'h0000, gpi_base | edge_bit, 8'h00);
        push_entry("rise again settle", op_wait, 16'h0000, 8'd2, 8'h00);
        write_reg("intc enable both", off_imask, 8'h03);
        expect_int("cpu_int both pending", 1'b1);
        expect_src("source both pending", src_gpio);
        write_reg("flag clear again", off_flags, edge_bit);
        write_reg("pending clear gpio again", off_pend, 8'h01);
        expect_src("source timer only", src_timer);
        expect_int("cpu_int timer only", 1'b1);
        write_reg("intc mask timer", off_imask, 8'h01);
        expect_int("cpu_int timer masked", 1'b0);
        read_reg("timer still pending", off_pend, 8'h02);
        expect_src("source timer masked", src_none);
    endtask

    task automatic drive_bus(input logic [15:0] a, input logic [7:0] d, input logic we);
        enable   <= 1'b1;
        addr     <= a;
        data_in  <= d;
        write_en <= we;
    endtask

    task automatic release_bus();
        enable   <= 1'b0;
        write_en <= 1'b0;
    endtask

    task automatic run_entry(input int i);
        entry_t e;
        e = tbl[i];
        @(posedge clk);
        case (e.op)
            op_write:              drive_bus(e.addr, e.data, 1'b1);
            op_read, op_check_src: drive_bus(e.addr, 8'h00, 1'b0);
            default:               release_bus();
        endcase
        case (e.op)
            op_read:
            begin
                @(negedge clk);
                check_data(names[i], e.expv, data_out);
                // a gpo read also checks the port
                if (e.addr == base_addr + 16'(off_gpo))
                    check_data({names[i], " port"}, e.expv, gpo);
            end
            op_set_gpi:
                gpi <= e.data;
            op_wait:
            begin
                if (e.data > 8'd1)
                    repeat (int'(e.data) - 1) @(posedge clk);
            end
            op_check_int:
            begin
                @(negedge clk);
                check_int(names[i], e.expv[0], cpu_int);
            end
            op_check_src:
            begin
                @(negedge clk);
                check_src(names[i], int_source_t'(e.expv[1:0]), int_source_t'(data_out[1:0]));
            end
            default:
                ;
        endcase
    endtask

    initial
    begin
        clk      = 1'b0;
        reset    = 1'b1;
        enable   = 1'b0;
        addr     = 16'h0000;
        data_in  = '0;
        write_en = 1'b0;
        gpi      = 8'h00;
        seed     = 32'he751;
        build_table();
        cycle_limit = n_entries * (max_wait + 4);

        repeat (16) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < n_entries; i++)
            run_entry(i);

        $display("errors: data %0d, cpu_int %0d, source %0d",
                 data_errors, int_errors, src_errors);
        if (data_errors + int_errors + src_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: timer/periph_timer.sv
/* down-counting timer with prescaler, reload register,
   run and auto-reload control and a one-cycle tick interrupt */
`timescale 1ns/10ps

module periph_timer
    import periph_bus_pkg::*, periph_map_pkg::*;
#(
    parameter int prescale = 4
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     sel,
    input  bus_req_t req,
    output bus_rsp_t rsp,
    output logic     irq
);

    localparam int pre_w = (prescale > 1) ? $clog2(prescale) : 1;

    logic [pre_w-1:0]      pre_cnt;
    logic                  run;
    logic                  auto_reload;
    logic [data_width-1:0] reload;
    logic [data_width-1:0] count;
    logic                  tick;

    assign tick = run && (pre_cnt == pre_w'(prescale - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pre_cnt     <= '0;
            run         <= 1'b0;
            auto_reload <= 1'b0;
            reload      <= '0;
            count       <= '0;
            irq         <= 1'b0;
        end
        else
        begin
            irq <= 1'b0;
            // prescaler only advances while running
            if (!run || tick)
                pre_cnt <= '0;
            else
                pre_cnt <= pre_cnt + 1'b1;

            if (tick)
            begin
                if (count == '0)
                begin
                    irq <= 1'b1;
                    if (auto_reload)
                        count <= reload;
                    else
                        run <= 1'b0;
                end
                else
                    count <= count - 1'b1;
            end

            // bus writes take priority over the tick
            if (req.we && req.offset == timer_reg_ctrl)
            begin
                run         <= req.wdata[0];
                auto_reload <= req.wdata[1];
            end
            if (req.we && req.offset == timer_reg_reload)
            begin
                reload <= req.wdata;
                count  <= req.wdata;
            end
        end
    end

    always_comb
    begin
        rsp.rdata = '0;
        if (sel)
        begin
            case (req.offset)
                timer_reg_ctrl:   rsp.rdata = {{(data_width-2){1'b0}}, auto_reload, run};
                timer_reg_reload: rsp.rdata = reload;
                timer_reg_count:  rsp.rdata = count;
                default:          rsp.rdata = '0;
            endcase
        end
    end

    a_irq_single_cycle: assert property (@(posedge clk) disable iff (reset)
        irq |=> !irq);

endmodule
